//--- bankram_top.f
+incdir+hdl
hdl/bankram_addr_pkg.sv
hdl/bankram_req_pkg.sv
hdl/bankram_dispatch.sv
hdl/bankram_bank.sv
hdl/bankram_collect.sv
hdl/bankram_top.sv
verif/bankram_sva.sv
verif/bankram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the banked memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f bankram_top.f \
    --top-module bankram_tb \
    -o bankram_sim

./obj_dir/bankram_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "PASS: testbench reported success"
    exit 0
fi

echo "FAIL: no success line found in sim.log"
exit 1

//--- verif/bankram_tb.sv
// Testbench for the banked memory: clock, reset, tests, shadow model, compare process, watchdog
`include "bankram_macros.svh"

module bankram_tb;
    import bankram_addr_pkg::*;
    import bankram_req_pkg::*;

    // Issue cycles of each test, the watchdog budget is built from these
    localparam int IDLE_CYCLES   = 16;
    localparam int FILL_CYCLES   = 128;
    localparam int PART_CYCLES   = 32;
    localparam int B2B_CYCLES    = 32;
    localparam int RAW_CYCLES    = 16;
    localparam int RAND_CYCLES   = 400;
    localparam int ISSUE_CYCLES  = IDLE_CYCLES + FILL_CYCLES + PART_CYCLES + B2B_CYCLES
                                   + RAW_CYCLES + RAND_CYCLES;
    localparam int WATCHDOG_TIME = (ISSUE_CYCLES + 50) * 4;

    // One expected response, due at the negative edge of cycle due
    typedef struct packed
    {
        int                            due;
        logic [`BANKRAM_DATA_BITS-1:0] word;
    } exp_t;

    logic                          clk0 = 1'b0;
    logic                          arst_n;
    port_req_t                     req0;
    port_req_t                     req1;
    port_resp_t                    resp0;
    port_resp_t                    resp1;
    logic [`BANKRAM_DATA_BITS-1:0] shadow [64];
    exp_t                          exp_q0 [$];
    exp_t                          exp_q1 [$];
    exp_t                          head0;
    exp_t                          head1;
    bit                            due0;
    bit                            due1;
    logic [31:0]                   rnd = 32'hd919_eddf;
    int                            cyc = 0;
    int                            err_count = 0;
    int                            check_count = 0;
    int                            tests_run = 0;
    int                            test_err_base = 0;

    bankram_top dut
    (
        .clk0   (clk0),
        .arst_n (arst_n),
        .req0   (req0),
        .req1   (req1),
        .resp0  (resp0),
        .resp1  (resp1)
    );

    always #2 clk0 = ~clk0;

    always @(posedge clk0)
        cyc <= cyc + 1;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference for a byte-enabled write: expand the enables to a bit mask
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [3:0] be,
                                                input logic [31:0] wdata);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    // Fill word that differs in every field for every one of the 64 addresses
    function automatic logic [31:0] fill_word(input logic [5:0] a);
        return {a, 2'b10, ~a, 2'b01, a, 4'h3, ~a};
    endfunction

    function automatic mem_op_e pick_op(input logic [1:0] s);
        case (s)
            2'd0:    return OP_NOP;
            2'd1:    return OP_READ;
            default: return OP_WRITE;
        endcase
    endfunction

    function automatic port_req_t make_req(input mem_op_e op, input logic [5:0] addr,
                                           input logic [3:0] be, input logic [31:0] wdata);
        port_req_t r;
        r.op      = op;
        r.addr    = mem_addr_t'(addr);
        r.byteena = be;
        r.wdata   = wdata;
        return r;
    endfunction

    function automatic port_req_t nop_req();
        return make_req(OP_NOP, 6'd0, 4'd0, 32'd0);
    endfunction

    // Writes update the shadow at once, reads queue the word they must return
    task automatic model_req(input int port, input port_req_t r);
        logic [5:0] a;
        exp_t       e;
        a = r.addr;
        if (r.op == OP_WRITE)
            shadow[a] = merge_bytes(shadow[a], r.byteena, r.wdata);
        else if (r.op == OP_READ)
        begin
            e.due  = cyc + `BANKRAM_READ_LATENCY;
            e.word = shadow[a];
            if (port == 0)
                exp_q0.push_back(e);
            else
                exp_q1.push_back(e);
        end
    endtask

    // Drive both ports just after the rising edge and record them in the model
    task automatic issue(input port_req_t r0, input port_req_t r1);
        @(posedge clk0);
        #1;
        req0 = r0;
        req1 = r1;
        model_req(0, r0);
        model_req(1, r1);
    endtask

    task automatic start_test();
        test_err_base = err_count;
    endtask

    // Idles the ports until every outstanding read has been answered
    task automatic end_test(input string name);
        while (exp_q0.size() != 0 || exp_q1.size() != 0)
            issue(nop_req(), nop_req());
        issue(nop_req(), nop_req());
        tests_run++;
        $display("Test %s finished with %0d errors", name, err_count - test_err_base);
    endtask

    task automatic check_port(input string name, input port_resp_t resp, input bit due,
                              input logic [31:0] expv);
        check_count++;
        assert (resp.valid === due)
        else
        begin
            err_count++;
            $display("Mismatch at %0t: %s.valid is %b, expected %b", $time, name,
                     resp.valid, due);
        end
        if (due)
        begin
            check_count++;
            assert (resp.rdata === expv)
            else
            begin
                err_count++;
                $display("Mismatch at %0t: %s.rdata is %h, expected %h", $time, name,
                         resp.rdata, expv);
            end
        end
    endtask

    // Outputs change on the rising edge, so they are compared on the falling one
    always @(negedge clk0)
    begin
        if (arst_n)
        begin
            head0 = (exp_q0.size() != 0) ? exp_q0[0] : '0;
            head1 = (exp_q1.size() != 0) ? exp_q1[0] : '0;
            due0  = (exp_q0.size() != 0) && (head0.due == cyc);
            due1  = (exp_q1.size() != 0) && (head1.due == cyc);
            check_port("resp0", resp0, due0, head0.word);
            check_port("resp1", resp1, due1, head1.word);
            if (due0)
                head0 = exp_q0.pop_front();
            if (due1)
                head1 = exp_q1.pop_front();
        end
    end

    // No reads at all, so the compare process expects both strobes to stay low
    task automatic test_idle_writes();
        start_test();
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            rnd = next_rand(rnd);
            if (i % 2 == 1)
                issue(make_req(OP_WRITE, 6'(i), rnd[3:0], rnd), nop_req());
            else
                issue(nop_req(), make_req(OP_WRITE, 6'(i + 32), rnd[7:4], ~rnd));
        end
        end_test("idle_writes");
    endtask

    // Consecutive addresses walk through all banks in turn
    task automatic test_fill_read();
        start_test();
        for (int i = 0; i < FILL_CYCLES / 2; i++)
            issue(make_req(OP_WRITE, 6'(i), 4'hf, fill_word(6'(i))), nop_req());
        for (int i = 0; i < FILL_CYCLES / 2; i++)
            issue(nop_req(), make_req(OP_READ, 6'(i), 4'h0, 32'd0));
        end_test("fill_read");
    endtask

    // Byte enables run through all 16 values, from none to single lanes to all
    task automatic test_partial();
        start_test();
        for (int i = 0; i < PART_CYCLES / 2; i++)
        begin
            rnd = next_rand(rnd);
            issue(nop_req(), make_req(OP_WRITE, 6'(i * 5), 4'(i), rnd));
        end
        for (int i = 0; i < PART_CYCLES / 2; i++)
            issue(make_req(OP_READ, 6'(i * 5), 4'h0, 32'd0), nop_req());
        end_test("partial_writes");
    endtask

    task automatic test_back_to_back();
        start_test();
        for (int i = 0; i < B2B_CYCLES; i++)
            issue(make_req(OP_READ, 6'(i), 4'h0, 32'd0),
                  make_req(OP_READ, 6'(63 - i), 4'h0, 32'd0));
        end_test("back_to_back_reads");
    endtask

    // Write on one port, then read the same word on the other port next cycle
    task automatic test_write_then_read();
        logic [5:0] a;
        start_test();
        for (int i = 0; i < RAW_CYCLES / 2; i++)
        begin
            rnd = next_rand(rnd);
            a   = rnd[5:0];
            if (i % 2 == 0)
            begin
                issue(make_req(OP_WRITE, a, 4'hf, rnd), nop_req());
                issue(nop_req(), make_req(OP_READ, a, 4'h0, 32'd0));
            end
            else
            begin
                issue(nop_req(), make_req(OP_WRITE, a, 4'hf, rnd));
                issue(make_req(OP_READ, a, 4'h0, 32'd0), nop_req());
            end
        end
        end_test("write_then_read");
    endtask

    task automatic test_random();
        mem_op_e     op0;
        mem_op_e     op1;
        logic [5:0]  a0;
        logic [5:0]  a1;
        logic [3:0]  be0;
        logic [3:0]  be1;
        logic [31:0] wd0;
        logic [31:0] wd1;
        start_test();
        for (int i = 0; i < RAND_CYCLES; i++)
        begin
            rnd = next_rand(rnd);
            op0 = pick_op(rnd[1:0]);
            op1 = pick_op(rnd[3:2]);
            a0  = rnd[13:8];
            a1  = rnd[21:16];
            be0 = rnd[27:24];
            be1 = rnd[31:28];
            // The same word on both ports with a write involved is undefined
            if (a1 == a0 && (op0 == OP_WRITE || op1 == OP_WRITE))
                a1 = a0 + 6'd1;
            rnd = next_rand(rnd);
            wd0 = rnd;
            rnd = next_rand(rnd);
            wd1 = rnd;
            issue(make_req(op0, a0, be0, wd0), make_req(op1, a1, be1, wd1));
        end
        end_test("random_traffic");
    endtask

    initial
    begin
        req0   = '0;
        req1   = '0;
        arst_n = 1'b0;
        repeat (4) @(posedge clk0);
        #1;
        arst_n = 1'b1;
        test_idle_writes();
        test_fill_read();
        test_partial();
        test_back_to_back();
        test_write_then_read();
        test_random();
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Budget is every issued cycle plus room for reset and pipeline drains
    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: tests still running after %0d time units", WATCHDOG_TIME);
        $display("sim failed");
        $finish;
    end

endmodule

//--- verif/bankram_sva.sv
// Bound checks on the banked memory top level: read latency, known read data, quiet reset
`include "bankram_macros.svh"

module bankram_sva
(
    input logic                        clk0,
    input logic                        arst_n,
    input bankram_req_pkg::port_req_t  req0,
    input bankram_req_pkg::port_req_t  req1,
    input bankram_req_pkg::port_resp_t resp0,
    input bankram_req_pkg::port_resp_t resp1
);
    import bankram_req_pkg::*;

    // A response shows up exactly when a read was issued on the same port
    // the fixed latency earlier, and at no other time
    a_lat0: assert property (@(posedge clk0) disable iff (!arst_n)
        resp0.valid == $past(req0.op == OP_READ, `BANKRAM_READ_LATENCY))
        else $error("port 0 response strobe does not follow its reads");
    a_lat1: assert property (@(posedge clk0) disable iff (!arst_n)
        resp1.valid == $past(req1.op == OP_READ, `BANKRAM_READ_LATENCY))
        else $error("port 1 response strobe does not follow its reads");

    // Read data carries no X or Z while it is being presented
    a_known0: assert property (@(posedge clk0) disable iff (!arst_n)
        resp0.valid |-> !$isunknown(resp0.rdata))
        else $error("port 0 read data has unknown bits");
    a_known1: assert property (@(posedge clk0) disable iff (!arst_n)
        resp1.valid |-> !$isunknown(resp1.rdata))
        else $error("port 1 read data has unknown bits");

    // No response may leave the memory while it is held in reset
    a_rst0: assert property (@(posedge clk0) !arst_n |-> !resp0.valid)
        else $error("port 0 response strobe high during reset");
    a_rst1: assert property (@(posedge clk0) !arst_n |-> !resp1.valid)
        else $error("port 1 response strobe high during reset");

endmodule

bind bankram_top bankram_sva u_sva
(
    .clk0   (clk0),
    .arst_n (arst_n),
    .req0   (req0),
    .req1   (req1),
    .resp0  (resp0),
    .resp1  (resp1)
);

//--- hdl/bankram_top.sv
// Banked dual-port memory top level: dispatch, bank array and response collector
`include "bankram_macros.svh"

module bankram_top
(
    input  logic                        clk0,
    input  logic                        arst_n,
    input  bankram_req_pkg::port_req_t  req0,
    input  bankram_req_pkg::port_req_t  req1,
    output bankram_req_pkg::port_resp_t resp0,
    output bankram_req_pkg::port_resp_t resp1
);
    import bankram_req_pkg::*;

    // Registered per-bank requests from the dispatcher
    bank_req_t                     bank_req0    [`BANKRAM_N_BANKS];
    bank_req_t                     bank_req1    [`BANKRAM_N_BANKS];

    // Read data and strobes coming back from each bank
    logic [`BANKRAM_DATA_BITS-1:0] bank_rdata0  [`BANKRAM_N_BANKS];
    logic [`BANKRAM_DATA_BITS-1:0] bank_rdata1  [`BANKRAM_N_BANKS];
    logic [`BANKRAM_N_BANKS-1:0]   bank_rvalid0;
    logic [`BANKRAM_N_BANKS-1:0]   bank_rvalid1;

    bankram_dispatch u_dispatch
    (
        .clk0      (clk0),
        .arst_n    (arst_n),
        .req0      (req0),
        .req1      (req1),
        .bank_req0 (bank_req0),
        .bank_req1 (bank_req1)
    );

    // One bank per interleave slot, each sees both ports
    for (genvar b = 0; b < `BANKRAM_N_BANKS; b++)
    begin : g_bank
        bankram_bank u_bank
        (
            .clk0    (clk0),
            .arst_n  (arst_n),
            .breq0   (bank_req0[b]),
            .breq1   (bank_req1[b]),
            .rdata0  (bank_rdata0[b]),
            .rdata1  (bank_rdata1[b]),
            .rvalid0 (bank_rvalid0[b]),
            .rvalid1 (bank_rvalid1[b])
        );
    end

    bankram_collect u_collect
    (
        .clk0    (clk0),
        .arst_n  (arst_n),
        .rdata0  (bank_rdata0),
        .rdata1  (bank_rdata1),
        .rvalid0 (bank_rvalid0),
        .rvalid1 (bank_rvalid1),
        .resp0   (resp0),
        .resp1   (resp1)
    );

endmodule

//--- hdl/bankram_collect.sv
// Response collector: one-hot merge of bank read data and the port response register
`include "bankram_macros.svh"

module bankram_collect
(
    input  logic                          clk0,
    input  logic                          arst_n,
    input  logic [`BANKRAM_DATA_BITS-1:0] rdata0 [`BANKRAM_N_BANKS],
    input  logic [`BANKRAM_DATA_BITS-1:0] rdata1 [`BANKRAM_N_BANKS],
    input  logic [`BANKRAM_N_BANKS-1:0]   rvalid0,
    input  logic [`BANKRAM_N_BANKS-1:0]   rvalid1,
    output bankram_req_pkg::port_resp_t   resp0,
    output bankram_req_pkg::port_resp_t   resp1
);
    import bankram_req_pkg::*;

    localparam int N_PORTS = 2;

    logic [`BANKRAM_DATA_BITS-1:0] rdata_in  [N_PORTS][`BANKRAM_N_BANKS];
    logic [`BANKRAM_N_BANKS-1:0]   rvalid_in [N_PORTS];
    logic [`BANKRAM_DATA_BITS-1:0] merged    [N_PORTS];
    logic                          any_vld   [N_PORTS];
    logic                          valid_q   [N_PORTS];
    logic [`BANKRAM_DATA_BITS-1:0] rdata_q   [N_PORTS];

    assign rdata_in[0]  = rdata0;
    assign rdata_in[1]  = rdata1;
    assign rvalid_in[0] = rvalid0;
    assign rvalid_in[1] = rvalid1;

    // Dispatch strobes one bank per port per cycle and every bank has the
    // same latency, so at most one rvalid per port is set.
    // An AND-OR merge is then enough and needs no priority logic
    always_comb
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            merged[p]  = '0;
            any_vld[p] = |rvalid_in[p];
            for (int b = 0; b < `BANKRAM_N_BANKS; b++)
            begin
                if (rvalid_in[p][b])
                    merged[p] = merged[p] | rdata_in[p][b];
            end
        end
    end

    // Response strobe is a single-cycle pulse per read
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int p = 0; p < N_PORTS; p++)
                valid_q[p] <= 1'b0;
        end
        else
        begin
            for (int p = 0; p < N_PORTS; p++)
                valid_q[p] <= any_vld[p];
        end
    end

    // Read data holds its last value between responses
    always_ff @(posedge clk0)
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            if (any_vld[p])
                rdata_q[p] <= merged[p];
        end
    end

    assign resp0 = '{valid: valid_q[0], rdata: rdata_q[0]};
    assign resp1 = '{valid: valid_q[1], rdata: rdata_q[1]};

endmodule

//--- hdl/bankram_bank.sv
// Bank RAM: true dual-port byte-enable array with read register and output stages
`include "bankram_macros.svh"

module bankram_bank
(
    input  logic                          clk0,
    input  logic                          arst_n,
    input  bankram_req_pkg::bank_req_t    breq0,
    input  bankram_req_pkg::bank_req_t    breq1,
    output logic [`BANKRAM_DATA_BITS-1:0] rdata0,
    output logic [`BANKRAM_DATA_BITS-1:0] rdata1,
    output logic                          rvalid0,
    output logic                          rvalid1
);
    import bankram_req_pkg::*;

    localparam int N_PORTS = 2;

    bank_req_t                     breq_in [N_PORTS];
    logic [`BANKRAM_DATA_BITS-1:0] mem     [`BANKRAM_ROWS];

    // Element 0 is the array read register and the rest are output stages
    logic [`BANKRAM_DATA_BITS-1:0] rd_pipe  [N_PORTS][0:`BANKRAM_BANK_STAGES];
    logic                          vld_pipe [N_PORTS][0:`BANKRAM_BANK_STAGES];

    assign breq_in[0] = breq0;
    assign breq_in[1] = breq1;

    // Array writes and reads.
    // A read sees the contents from before this edge, so a write on the
    // other port to the same row in the same cycle gives old data.
    // Writes from earlier cycles are always visible
    always_ff @(posedge clk0)
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            if (breq_in[p].wr)
            begin
                // Only enabled byte lanes are touched
                for (int i = 0; i < `BANKRAM_N_BYTES; i++)
                begin
                    if (breq_in[p].byteena[i])
                        mem[breq_in[p].row][i*`BANKRAM_BYTE_BITS +: `BANKRAM_BYTE_BITS] <=
                            breq_in[p].wdata[i*`BANKRAM_BYTE_BITS +: `BANKRAM_BYTE_BITS];
                end
            end
            if (breq_in[p].rd)
                rd_pipe[p][0] <= mem[breq_in[p].row];
        end
    end

    // Valid strobe matching the array read register
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int p = 0; p < N_PORTS; p++)
                vld_pipe[p][0] <= 1'b0;
        end
        else
        begin
            for (int p = 0; p < N_PORTS; p++)
                vld_pipe[p][0] <= breq_in[p].rd;
        end
    end

    // Output register stages where data and strobe move in step
    for (genvar s = 0; s < `BANKRAM_BANK_STAGES; s++)
    begin : g_stage
        always_ff @(posedge clk0)
        begin
            for (int p = 0; p < N_PORTS; p++)
                rd_pipe[p][s+1] <= rd_pipe[p][s];
        end

        always_ff @(posedge clk0 or negedge arst_n)
        begin
            if (!arst_n)
            begin
                for (int p = 0; p < N_PORTS; p++)
                    vld_pipe[p][s+1] <= 1'b0;
            end
            else
            begin
                for (int p = 0; p < N_PORTS; p++)
                    vld_pipe[p][s+1] <= vld_pipe[p][s];
            end
        end
    end

    assign rdata0  = rd_pipe[0][`BANKRAM_BANK_STAGES];
    assign rdata1  = rd_pipe[1][`BANKRAM_BANK_STAGES];
    assign rvalid0 = vld_pipe[0][`BANKRAM_BANK_STAGES];
    assign rvalid1 = vld_pipe[1][`BANKRAM_BANK_STAGES];

endmodule

//--- hdl/bankram_dispatch.sv
// Request dispatch: opcode and bank decode, registered per-bank requests
`include "bankram_macros.svh"

module bankram_dispatch
(
    input  logic                       clk0,
    input  logic                       arst_n,
    input  bankram_req_pkg::port_req_t req0,
    input  bankram_req_pkg::port_req_t req1,
    output bankram_req_pkg::bank_req_t bank_req0 [`BANKRAM_N_BANKS],
    output bankram_req_pkg::bank_req_t bank_req1 [`BANKRAM_N_BANKS]
);
    import bankram_addr_pkg::*;
    import bankram_req_pkg::*;

    localparam int N_PORTS = 2;

    // Both ports are handled by the same loops with index 0 as port 0
    port_req_t                     req_in  [N_PORTS];
    logic [`BANKRAM_N_BANKS-1:0]   rd_sel  [N_PORTS];
    logic [`BANKRAM_N_BANKS-1:0]   wr_sel  [N_PORTS];
    logic [`BANKRAM_N_BANKS-1:0]   rd_q    [N_PORTS];
    logic [`BANKRAM_N_BANKS-1:0]   wr_q    [N_PORTS];
    row_idx_t                      row_q   [N_PORTS];
    logic [`BANKRAM_N_BYTES-1:0]   be_q    [N_PORTS];
    logic [`BANKRAM_DATA_BITS-1:0] wdata_q [N_PORTS];

    assign req_in[0] = req0;
    assign req_in[1] = req1;

    // One-hot bank select per port, qualified by the opcode.
    // OP_NOP leaves both vectors at zero
    always_comb
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            rd_sel[p] = '0;
            wr_sel[p] = '0;
            if (req_in[p].op == OP_READ)
                rd_sel[p][req_in[p].addr.bank] = 1'b1;
            if (req_in[p].op == OP_WRITE)
                wr_sel[p][req_in[p].addr.bank] = 1'b1;
        end
    end

    // Registered one-hot strobes of each port
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int p = 0; p < N_PORTS; p++)
            begin
                rd_q[p] <= '0;
                wr_q[p] <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < N_PORTS; p++)
            begin
                rd_q[p] <= rd_sel[p];
                wr_q[p] <= wr_sel[p];
            end
        end
    end

    // Payload is shared by all banks of a port and only loads on a real operation
    always_ff @(posedge clk0)
    begin
        for (int p = 0; p < N_PORTS; p++)
        begin
            if (req_in[p].op != OP_NOP)
            begin
                row_q[p]   <= req_in[p].addr.row;
                be_q[p]    <= req_in[p].byteena;
                wdata_q[p] <= req_in[p].wdata;
            end
        end
    end

    // Fan the registered request out to every bank with its own strobes
    always_comb
    begin
        for (int b = 0; b < `BANKRAM_N_BANKS; b++)
        begin
            bank_req0[b] = '{rd: rd_q[0][b], wr: wr_q[0][b], row: row_q[0],
                             byteena: be_q[0], wdata: wdata_q[0]};
            bank_req1[b] = '{rd: rd_q[1][b], wr: wr_q[1][b], row: row_q[1],
                             byteena: be_q[1], wdata: wdata_q[1]};
        end
    end

endmodule

//--- hdl/bankram_req_pkg.sv
// Request and response types: opcode enum, port request, bank request, port response
`include "bankram_macros.svh"

package bankram_req_pkg;

    // Port opcode, one operation per port per cycle
    typedef enum logic [1:0]
    {
        OP_NOP   = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    // Request as presented on an external port.
    // byteena and wdata only matter for OP_WRITE
    typedef struct packed
    {
        mem_op_e                       op;
        bankram_addr_pkg::mem_addr_t   addr;
        logic [`BANKRAM_N_BYTES-1:0]   byteena;
        logic [`BANKRAM_DATA_BITS-1:0] wdata;
    } port_req_t;

    // Request for one bank after decode.
    // At most one of rd and wr is set, and only in the addressed bank
    typedef struct packed
    {
        logic                          rd;
        logic                          wr;
        bankram_addr_pkg::row_idx_t    row;
        logic [`BANKRAM_N_BYTES-1:0]   byteena;
        logic [`BANKRAM_DATA_BITS-1:0] wdata;
    } bank_req_t;

    // Read response on an external port, valid for one cycle per read
    typedef struct packed
    {
        logic                          valid;
        logic [`BANKRAM_DATA_BITS-1:0] rdata;
    } port_resp_t;

endpackage

//--- hdl/bankram_addr_pkg.sv
// Address types: bank index, row index and the split word address
`include "bankram_macros.svh"

package bankram_addr_pkg;

    // Bank number taken from the low address bits
    typedef logic [$clog2(`BANKRAM_N_BANKS)-1:0] bank_idx_t;

    // Row inside one bank, taken from the high address bits
    typedef logic [$clog2(`BANKRAM_ROWS)-1:0] row_idx_t;

    // Word address as seen by a port.
    // The bank sits in the low bits so that consecutive words land in
    // consecutive banks
    typedef struct packed
    {
        row_idx_t  row;
        bank_idx_t bank;
    } mem_addr_t;

endpackage

//--- hdl/bankram_macros.svh
// Memory geometry and pipeline latency macros for the banked RAM
`ifndef BANKRAM_MACROS_SVH
`define BANKRAM_MACROS_SVH

// Width of one data word in bits
`define BANKRAM_DATA_BITS 32

// Width of one byte lane, the unit that a byte enable controls
`define BANKRAM_BYTE_BITS 8

// Byte lanes per word, so one byte enable bit per lane
`define BANKRAM_N_BYTES 4

// Number of interleaved banks, selected by the low address bits
`define BANKRAM_N_BANKS 4

// Words held in each bank
`define BANKRAM_ROWS 16

// Output register stages inside a bank after the array read register
`define BANKRAM_BANK_STAGES 1

// Request to response latency seen at the top level.
// Dispatch, array read and collect each add one stage on top of the bank
// output stages
`define BANKRAM_READ_LATENCY (`BANKRAM_BANK_STAGES + 3)

`endif
